// File: Makefile
# Verilator build and run for the harness glue testbench

TOP := tb_harness_glue
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard hw/*.sv include/*.svh verification/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --top-module harness_glue_top +incdir+include \
		hw/harness_pkg.sv hw/periph_addr_decode.sv hw/periph_reg_demux.sv \
		hw/powergate_ack_delay.sv hw/harness_glue_top.sv
	verilator --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+include
hw/harness_pkg.sv
hw/periph_addr_decode.sv
hw/periph_reg_demux.sv
hw/powergate_ack_delay.sv
hw/harness_glue_top.sv
verification/tb_harness_glue.sv

// File: hw/harness_glue_top.sv
//////////////////////////////
// harness glue top level
// bus routing, switch acks, irq and dma vectors
//////////////////////////////
`include "harness_defines.svh"

module harness_glue_top (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  // register bus
  input  logic                                             reg_valid_i,
  input  logic                                             reg_write_i,
  input  harness_pkg::reg_addr_t                           reg_addr_i,
  input  harness_pkg::reg_data_t                           reg_wdata_i,
  input  harness_pkg::reg_strb_t                           reg_wstrb_i,
  output harness_pkg::reg_data_t                           reg_rdata_o,
  output logic                                             reg_error_o,
  output logic                                             reg_ready_o,
  // peripheral ports
  output logic [`HARNESS_EXT_NPERIPH-1:0]                  periph_valid_o,
  output logic                                             periph_write_o,
  output harness_pkg::reg_addr_t                           periph_addr_o,
  output harness_pkg::reg_data_t                           periph_wdata_o,
  output harness_pkg::reg_strb_t                           periph_wstrb_o,
  input  harness_pkg::reg_data_t [`HARNESS_EXT_NPERIPH-1:0] periph_rdata_i,
  input  logic [`HARNESS_EXT_NPERIPH-1:0]                  periph_error_i,
  input  logic [`HARNESS_EXT_NPERIPH-1:0]                  periph_ready_i,
  // power switch requests and acks, active low
  input  logic                                             cpu_switch_n_i,
  input  logic                                             periph_switch_n_i,
  input  harness_pkg::bank_vec_t                           banks_switch_n_i,
  input  harness_pkg::domain_vec_t                         ext_switch_n_i,
  output logic                                             cpu_switch_ack_n_o,
  output logic                                             periph_switch_ack_n_o,
  output harness_pkg::bank_vec_t                           banks_switch_ack_n_o,
  output harness_pkg::domain_vec_t                         ext_switch_ack_n_o,
  // interrupts
  input  logic                                             memcopy_intr_i,
  input  logic                                             iffifo_intr_i,
  output harness_pkg::intr_vec_t                           intr_vector_ext_o,
  // dma trigger levels
  input  logic                                             iffifo_in_ready_i,
  input  logic                                             iffifo_out_valid_i,
  output harness_pkg::dma_slot_vec_t                       dma_slot_tx_o,
  output harness_pkg::dma_slot_vec_t                       dma_slot_rx_o
);

  harness_pkg::periph_idx_t dec_idx;
  logic                     dec_valid;
  logic                     dec_error;

  periph_addr_decode u_addr_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .addr_i      (reg_addr_i),
    .idx_o       (dec_idx),
    .dec_valid_o (dec_valid),
    .dec_error_o (dec_error)
  );

  periph_reg_demux u_reg_demux (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .reg_valid_i    (reg_valid_i),
    .reg_write_i    (reg_write_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_wstrb_i    (reg_wstrb_i),
    .sel_idx_i      (dec_idx),
    .sel_valid_i    (dec_valid),
    .reg_rdata_o    (reg_rdata_o),
    .reg_error_o    (reg_error_o),
    .reg_ready_o    (reg_ready_o),
    .periph_valid_o (periph_valid_o),
    .periph_write_o (periph_write_o),
    .periph_addr_o  (periph_addr_o),
    .periph_wdata_o (periph_wdata_o),
    .periph_wstrb_o (periph_wstrb_o),
    .periph_rdata_i (periph_rdata_i),
    .periph_error_i (periph_error_i),
    .periph_ready_i (periph_ready_i)
  );

  // a decode miss ends in an immediate error with no port touched
  assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (reg_valid_i && dec_error) |->
      (reg_ready_o && reg_error_o && (reg_rdata_o == '0) && (periph_valid_o == '0))
  ) else $error("unmapped access not answered with error");

  // switch cell models, one per domain group
  powergate_ack_delay #(
    .payload_t (logic)
  ) u_cpu_ack_delay (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (cpu_switch_n_i),
    .switch_ack_n_o (cpu_switch_ack_n_o)
  );

  powergate_ack_delay #(
    .payload_t (logic)
  ) u_periph_ack_delay (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (periph_switch_n_i),
    .switch_ack_n_o (periph_switch_ack_n_o)
  );

  powergate_ack_delay #(
    .payload_t (harness_pkg::bank_vec_t)
  ) u_banks_ack_delay (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (banks_switch_n_i),
    .switch_ack_n_o (banks_switch_ack_n_o)
  );

  powergate_ack_delay #(
    .payload_t (harness_pkg::domain_vec_t)
  ) u_ext_ack_delay (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .switch_n_i     (ext_switch_n_i),
    .switch_ack_n_o (ext_switch_ack_n_o)
  );

  // unused interrupt lines tied low
  always_comb begin
    intr_vector_ext_o    = '0;
    intr_vector_ext_o[0] = memcopy_intr_i;
    intr_vector_ext_o[1] = iffifo_intr_i;
  end

  // only slot 0 is wired to the interface fifo
  always_comb begin
    dma_slot_tx_o    = '0;
    dma_slot_rx_o    = '0;
    dma_slot_tx_o[0] = iffifo_in_ready_i;
    dma_slot_rx_o[0] = iffifo_out_valid_i;
  end

endmodule

// File: hw/harness_pkg.sv
//////////////////////////////
// harness glue types
// bus fields, vectors, address rule table
//////////////////////////////
`include "harness_defines.svh"

package harness_pkg;

  // register bus fields
  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_strb_t;

  // peripheral port select
  typedef logic [1:0] periph_idx_t;

  // one window of the address map, end is exclusive
  typedef struct packed {
    periph_idx_t idx;
    reg_addr_t   start_addr;
    reg_addr_t   end_addr;
  } addr_rule_t;

  typedef addr_rule_t [`HARNESS_EXT_NPERIPH-1:0] addr_rule_tbl_t;

  // power and event vectors
  typedef logic [`HARNESS_NUM_BANKS-1:0]   bank_vec_t;
  typedef logic [`HARNESS_EXT_DOMAINS-1:0] domain_vec_t;
  typedef logic [`HARNESS_NEXT_INT-1:0]    intr_vec_t;
  typedef logic [`HARNESS_DMA_CH_NUM-1:0]  dma_slot_vec_t;

  // windows are laid out back to back from the base
  function automatic addr_rule_tbl_t gen_periph_rules();
    addr_rule_tbl_t tbl;
    for (int i = 0; i < `HARNESS_EXT_NPERIPH; i++) begin
      tbl[i].idx        = periph_idx_t'(i);
      tbl[i].start_addr = reg_addr_t'(`HARNESS_PERIPH_BASE + i * `HARNESS_PERIPH_SPAN);
      tbl[i].end_addr   = reg_addr_t'(`HARNESS_PERIPH_BASE + (i + 1) * `HARNESS_PERIPH_SPAN);
    end
    return tbl;
  endfunction

  localparam addr_rule_tbl_t PERIPH_ADDR_RULES = gen_periph_rules();

endpackage

// File: hw/periph_addr_decode.sv
//////////////////////////////
// register bus address decoder
// rule table lookup to port index
//////////////////////////////
`include "harness_defines.svh"

module periph_addr_decode (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  harness_pkg::reg_addr_t    addr_i,
  output harness_pkg::periph_idx_t  idx_o,
  output logic                      dec_valid_o,
  output logic                      dec_error_o
);

  // windows never overlap so at most one rule hits
  always_comb begin
    idx_o       = '0;
    dec_valid_o = 1'b0;
    for (int i = 0; i < `HARNESS_EXT_NPERIPH; i++) begin
      if ((addr_i >= harness_pkg::PERIPH_ADDR_RULES[i].start_addr) &&
          (addr_i <  harness_pkg::PERIPH_ADDR_RULES[i].end_addr)) begin
        idx_o       = harness_pkg::PERIPH_ADDR_RULES[i].idx;
        dec_valid_o = 1'b1;
      end
    end
  end

  // outside the span covered by all windows
  assign dec_error_o =
    (addr_i <  harness_pkg::PERIPH_ADDR_RULES[0].start_addr) ||
    (addr_i >= harness_pkg::PERIPH_ADDR_RULES[`HARNESS_EXT_NPERIPH-1].end_addr);

  // exactly one of hit and miss
  assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    dec_valid_o != dec_error_o
  ) else $error("decode valid and error not exclusive");

endmodule

// File: hw/periph_reg_demux.sv
//////////////////////////////
// register bus demultiplexer
// request fan-out, response select
//////////////////////////////
`include "harness_defines.svh"

module periph_reg_demux (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  // bus request side
  input  logic                                             reg_valid_i,
  input  logic                                             reg_write_i,
  input  harness_pkg::reg_addr_t                           reg_addr_i,
  input  harness_pkg::reg_data_t                           reg_wdata_i,
  input  harness_pkg::reg_strb_t                           reg_wstrb_i,
  // decoder result
  input  harness_pkg::periph_idx_t                         sel_idx_i,
  input  logic                                             sel_valid_i,
  // bus response side
  output harness_pkg::reg_data_t                           reg_rdata_o,
  output logic                                             reg_error_o,
  output logic                                             reg_ready_o,
  // peripheral ports
  output logic [`HARNESS_EXT_NPERIPH-1:0]                  periph_valid_o,
  output logic                                             periph_write_o,
  output harness_pkg::reg_addr_t                           periph_addr_o,
  output harness_pkg::reg_data_t                           periph_wdata_o,
  output harness_pkg::reg_strb_t                           periph_wstrb_o,
  input  harness_pkg::reg_data_t [`HARNESS_EXT_NPERIPH-1:0] periph_rdata_i,
  input  logic [`HARNESS_EXT_NPERIPH-1:0]                  periph_error_i,
  input  logic [`HARNESS_EXT_NPERIPH-1:0]                  periph_ready_i
);

  // shared request fields go to every port
  assign periph_write_o = reg_write_i;
  assign periph_addr_o  = reg_addr_i;
  assign periph_wdata_o = reg_wdata_i;
  assign periph_wstrb_o = reg_wstrb_i;

  // only the selected port sees valid
  always_comb begin
    periph_valid_o = '0;
    if (reg_valid_i && sel_valid_i) begin
      periph_valid_o[sel_idx_i] = 1'b1;
    end
  end

  // response from the selected port
  always_comb begin
    if (sel_valid_i) begin
      reg_rdata_o = periph_rdata_i[sel_idx_i];
      reg_error_o = periph_error_i[sel_idx_i];
      reg_ready_o = periph_ready_i[sel_idx_i];
    end else begin
      // unmapped address, answered right away
      reg_rdata_o = '0;
      reg_error_o = 1'b1;
      reg_ready_o = 1'b1;
    end
  end

  // never two ports selected
  assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(periph_valid_o)
  ) else $error("more than one peripheral port valid");

  // stalled requests stay put until ready
  assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (reg_valid_i && !reg_ready_o) |=> (reg_valid_i && $stable(reg_addr_i))
  ) else $error("request dropped or changed before ready");

endmodule

// File: hw/powergate_ack_delay.sv
//////////////////////////////
// power switch ack model
// fixed delay shift line
//////////////////////////////
`include "harness_defines.svh"

module powergate_ack_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned LATENCY   = `HARNESS_SWITCH_ACK_LATENCY
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t switch_n_i,
  output payload_t switch_ack_n_o
);

  // one register per switch cell stage
  payload_t stage_q [LATENCY];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // all switches start open
      for (int i = 0; i < LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // last stage is the ack
  assign switch_ack_n_o = stage_q[LATENCY-1];

  // ack is always known once out of reset
  assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(switch_ack_n_o)
  ) else $error("switch ack unknown");

endmodule

// File: include/harness_defines.svh
//////////////////////////////
// harness glue build constants
// port counts, address map, switch latency
//////////////////////////////
`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

// external register bus fan-out
`define HARNESS_EXT_NPERIPH 4

// peripheral windows, one span per port starting at base
`define HARNESS_PERIPH_BASE 32'h2000_0000
`define HARNESS_PERIPH_SPAN 32'h1000

// stages of the power switch ack model
`define HARNESS_SWITCH_ACK_LATENCY 15

// power domains seen by the glue
`define HARNESS_NUM_BANKS 2
`define HARNESS_EXT_DOMAINS 2

// external interrupt lines
`define HARNESS_NEXT_INT 4

// dma trigger slots
`define HARNESS_DMA_CH_NUM 2

`endif

// File: verification/tb_harness_glue.sv
//////////////////////////////
// harness glue testbench
// bus table, switch acks, irq/dma vectors
//////////////////////////////
`include "harness_defines.svh"

module tb_harness_glue;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NPORT          = `HARNESS_EXT_NPERIPH;
  localparam int SW_W           = 2 + `HARNESS_NUM_BANKS + `HARNESS_EXT_DOMAINS;
  localparam int MAX_STALL      = 4;
  localparam int NUM_ENTRIES    = 10;
  localparam int NUM_RANDOM     = 12;
  localparam int DELAY_TESTS    = 6;
  localparam int VEC_COMBOS     = 16;
  localparam int TIMEOUT_MARGIN = 50;
  localparam logic [31:0] SEED  = 32'd7132;
  localparam int TIMEOUT_CYCLES = (NUM_ENTRIES + NUM_RANDOM) * (MAX_STALL + 2)
                                + DELAY_TESTS * (`HARNESS_SWITCH_ACK_LATENCY + 5)
                                + VEC_COMBOS * 2 + TIMEOUT_MARGIN;

  typedef logic [NPORT-1:0] sel_t;

  // read data each peripheral stand-in returns
  localparam logic [31:0] PORT_CODE [NPORT] = '{
    32'hA5A5_0000, 32'h5A5A_0011, 32'hC3C3_0022, 32'h3C3C_0033
  };

  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    sel_t        exp_valid;
    logic        exp_error;
    logic [31:0] exp_data;
    logic [2:0]  stall;
  } access_t;

  localparam access_t ACCESS_TBL [NUM_ENTRIES] = '{
    '{32'h2000_0000, 1'b0, 4'b0001, 1'b0, 32'hA5A5_0000, 3'd0},
    '{32'h2000_0FFC, 1'b1, 4'b0001, 1'b0, 32'hA5A5_0000, 3'd2},
    '{32'h2000_1000, 1'b0, 4'b0010, 1'b0, 32'h5A5A_0011, 3'd0},
    '{32'h2000_1A04, 1'b0, 4'b0010, 1'b0, 32'h5A5A_0011, 3'd3},
    '{32'h2000_2010, 1'b1, 4'b0100, 1'b0, 32'hC3C3_0022, 3'd1},
    '{32'h2000_3FFC, 1'b0, 4'b1000, 1'b0, 32'h3C3C_0033, 3'd4},
    // just past the last window and just below the first
    '{32'h2000_4000, 1'b0, 4'b0000, 1'b1, 32'h0000_0000, 3'd0},
    '{32'h1FFF_FFFC, 1'b0, 4'b0000, 1'b1, 32'h0000_0000, 3'd0},
    '{32'h0000_0000, 1'b1, 4'b0000, 1'b1, 32'h0000_0000, 3'd0},
    '{32'hFFFF_F000, 1'b0, 4'b0000, 1'b1, 32'h0000_0000, 3'd0}
  };

  // ones mark the toggled switch lines in {ext, banks, periph, cpu} order
  localparam logic [SW_W-1:0] SWITCH_MASK [DELAY_TESTS] = '{
    6'b000001, 6'b000010, 6'b001100, 6'b110000, 6'b001000, 6'b010000
  };

  logic                                            clk_i;
  logic                                            arst_n_i;
  logic                                            reg_valid_i;
  logic                                            reg_write_i;
  harness_pkg::reg_addr_t                          reg_addr_i;
  harness_pkg::reg_data_t                          reg_wdata_i;
  harness_pkg::reg_strb_t                          reg_wstrb_i;
  harness_pkg::reg_data_t                          reg_rdata_o;
  logic                                            reg_error_o;
  logic                                            reg_ready_o;
  sel_t                                            periph_valid_o;
  logic                                            periph_write_o;
  harness_pkg::reg_addr_t                          periph_addr_o;
  harness_pkg::reg_data_t                          periph_wdata_o;
  harness_pkg::reg_strb_t                          periph_wstrb_o;
  harness_pkg::reg_data_t [NPORT-1:0]              periph_rdata_i;
  sel_t                                            periph_error_i;
  sel_t                                            periph_ready_i;
  logic                                            cpu_switch_n_i;
  logic                                            periph_switch_n_i;
  harness_pkg::bank_vec_t                          banks_switch_n_i;
  harness_pkg::domain_vec_t                        ext_switch_n_i;
  logic                                            cpu_switch_ack_n_o;
  logic                                            periph_switch_ack_n_o;
  harness_pkg::bank_vec_t                          banks_switch_ack_n_o;
  harness_pkg::domain_vec_t                        ext_switch_ack_n_o;
  logic                                            memcopy_intr_i;
  logic                                            iffifo_intr_i;
  harness_pkg::intr_vec_t                          intr_vector_ext_o;
  logic                                            iffifo_in_ready_i;
  logic                                            iffifo_out_valid_i;
  harness_pkg::dma_slot_vec_t                      dma_slot_tx_o;
  harness_pkg::dma_slot_vec_t                      dma_slot_rx_o;

  logic [SW_W-1:0] switch_req;
  logic [SW_W-1:0] ack_bits;
  int              stall_cycles = 0;
  int              wait_cnt = 0;
  int              cycle_cnt = 0;

  assign {ext_switch_n_i, banks_switch_n_i, periph_switch_n_i, cpu_switch_n_i} = switch_req;
  assign ack_bits = {ext_switch_ack_n_o, banks_switch_ack_n_o,
                     periph_switch_ack_n_o, cpu_switch_ack_n_o};

  harness_glue_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // peripheral stand-in raises ready after the entry's stall count
  assign periph_error_i = '0;
  assign periph_ready_i = {NPORT{wait_cnt >= stall_cycles}};

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_cnt <= 0;
    end else if ((|periph_valid_o) && !reg_ready_o) begin
      wait_cnt <= wait_cnt + 1;
    end else begin
      wait_cnt <= 0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL at %t: %s is %0h, expected %0h", $realtime, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // port index of back to back windows, -1 when unmapped
  function automatic int expected_port(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - `HARNESS_PERIPH_BASE;
    if (addr < `HARNESS_PERIPH_BASE) return -1;
    if (offset >= NPORT * `HARNESS_PERIPH_SPAN) return -1;
    return int'(offset / `HARNESS_PERIPH_SPAN);
  endfunction

  // hold the request until ready and count the stalled cycles
  task automatic run_access(input logic [31:0] addr, input logic write, input sel_t exp_valid,
                            input logic exp_error, input logic [31:0] exp_data, input int stall);
    int          low_cycles;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    low_cycles = 0;
    wdata      = ~addr;
    wstrb      = write ? 4'hF : 4'h0;
    @(posedge clk_i);
    #1;
    stall_cycles = stall;
    reg_valid_i  = 1'b1;
    reg_write_i  = write;
    reg_addr_i   = addr;
    reg_wdata_i  = wdata;
    reg_wstrb_i  = wstrb;
    @(negedge clk_i);
    while (reg_ready_o !== 1'b1) begin
      check_value(64'(periph_valid_o), 64'(exp_valid), "port select while stalled");
      low_cycles++;
      @(negedge clk_i);
    end
    check_value(64'(low_cycles), 64'(stall), "cycles with bus ready low");
    check_value(64'(periph_valid_o), 64'(exp_valid), "port select");
    check_value(64'(reg_error_o), 64'(exp_error), "error response");
    check_value(64'(reg_rdata_o), 64'(exp_data), "read data");
    check_value(64'(periph_addr_o), 64'(addr), "address fan-out");
    check_value(64'(periph_write_o), 64'(write), "write flag fan-out");
    check_value(64'(periph_wdata_o), 64'(wdata), "write data fan-out");
    check_value(64'(periph_wstrb_o), 64'(wstrb), "byte strobe fan-out");
    @(posedge clk_i);
    #1;
    reg_valid_i  = 1'b0;
    stall_cycles = 0;
  endtask

  task automatic check_switch_line(input logic [SW_W-1:0] mask);
    logic [SW_W-1:0] old_val;
    logic [SW_W-1:0] new_val;
    old_val = switch_req;
    new_val = switch_req ^ mask;
    @(posedge clk_i);
    #1;
    switch_req = new_val;
    // edge k takes the new request and the wait runs up to edge k+13
    @(posedge clk_i);
    repeat (`HARNESS_SWITCH_ACK_LATENCY - 2) @(posedge clk_i);
    @(negedge clk_i);
    check_value(64'(ack_bits), 64'(old_val), "switch ack one edge early");
    @(posedge clk_i);
    @(negedge clk_i);
    check_value(64'(ack_bits), 64'(new_val), "switch ack after full latency");
  endtask

  initial begin
    logic [31:0]                rnd;
    logic [31:0]                addr;
    int                         port;
    int                         stall;
    harness_pkg::intr_vec_t     exp_intr;
    harness_pkg::dma_slot_vec_t exp_tx;
    harness_pkg::dma_slot_vec_t exp_rx;
    $timeformat(-9, 1, " ns", 10);
    arst_n_i           = 1'b0;
    reg_valid_i        = 1'b0;
    reg_write_i        = 1'b0;
    reg_addr_i         = '0;
    reg_wdata_i        = '0;
    reg_wstrb_i        = '0;
    switch_req         = '1;
    memcopy_intr_i     = 1'b0;
    iffifo_intr_i      = 1'b0;
    iffifo_in_ready_i  = 1'b0;
    iffifo_out_valid_i = 1'b0;
    for (int p = 0; p < NPORT; p++) begin
      periph_rdata_i[p] = PORT_CODE[p];
    end
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // every switch open and no port selected
    @(negedge clk_i);
    check_value(64'(ack_bits), 64'({SW_W{1'b1}}), "switch acks after reset");
    check_value(64'(periph_valid_o), 64'(0), "port select while idle");

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_access(ACCESS_TBL[i].addr, ACCESS_TBL[i].write, ACCESS_TBL[i].exp_valid,
                 ACCESS_TBL[i].exp_error, ACCESS_TBL[i].exp_data, int'(ACCESS_TBL[i].stall));
    end

    // random addresses around the mapped region
    rnd = SEED;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd  = xorshift32(rnd);
      addr = 32'h1FFF_E000 + {17'd0, rnd[14:2], 2'b00};
      port = expected_port(addr);
      if (port < 0) begin
        run_access(addr, rnd[24], '0, 1'b1, 32'h0, 0);
      end else begin
        stall = int'(rnd[19:17]) % (MAX_STALL + 1);
        run_access(addr, rnd[24], sel_t'(1 << port), 1'b0, PORT_CODE[port], stall);
      end
    end

    for (int t = 0; t < DELAY_TESTS; t++) begin
      check_switch_line(SWITCH_MASK[t]);
    end

    for (int combo = 0; combo < VEC_COMBOS; combo++) begin
      @(posedge clk_i);
      #1;
      {memcopy_intr_i, iffifo_intr_i, iffifo_in_ready_i, iffifo_out_valid_i} = combo[3:0];
      exp_intr    = '0;
      exp_intr[0] = combo[3];
      exp_intr[1] = combo[2];
      exp_tx      = '0;
      exp_tx[0]   = combo[1];
      exp_rx      = '0;
      exp_rx[0]   = combo[0];
      @(negedge clk_i);
      check_value(64'(intr_vector_ext_o), 64'(exp_intr), "interrupt vector");
      check_value(64'(dma_slot_tx_o), 64'(exp_tx), "dma tx slots");
      check_value(64'(dma_slot_rx_o), 64'(exp_rx), "dma rx slots");
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule
